//--- Bender.yml
package:
  name: edge_job_control

sources:
  - logic/mem_pkg.sv
  - logic/graph_pkg.sv
  - logic/edge_base_regs.sv
  - logic/edge_read_sequencer.sv
  - logic/edge_cacheline_stream.sv
  - logic/edge_job_fifo.sv
  - logic/edge_job_control.sv
  - target: test
    files:
      - tb/tb_edge_job_control.sv

//--- edge_job_control.f
logic/mem_pkg.sv
logic/graph_pkg.sv
logic/edge_base_regs.sv
logic/edge_read_sequencer.sv
logic/edge_cacheline_stream.sv
logic/edge_job_fifo.sv
logic/edge_job_control.sv
tb/tb_edge_job_control.sv

//--- logic/edge_base_regs.sv
// edge array base registers
module edge_base_regs (
	input  logic                clock,
	input  logic                rstn,
	input  logic                cfg_write,
	input  mem_pkg::array_tag_t cfg_tag,
	input  mem_pkg::addr_t      cfg_addr,
	output mem_pkg::addr_t      src_base,
	output mem_pkg::addr_t      dest_base,
	output mem_pkg::addr_t      weight_base
);
	import mem_pkg::*;

	// one register per array, selected by tag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			src_base    <= '0;
			dest_base   <= '0;
			weight_base <= '0;
		end else if (cfg_write) begin
			case (cfg_tag)
				array_src: begin
					src_base <= cfg_addr;
				end
				array_dest: begin
					dest_base <= cfg_addr;
				end
				array_weight: begin
					weight_base <= cfg_addr;
				end
				default: begin
					src_base <= src_base;
				end
			endcase
		end
	end

endmodule

//--- logic/edge_cacheline_stream.sv
// cacheline element stream
module edge_cacheline_stream #(
	parameter type                 elem_t = logic [31:0],
	parameter mem_pkg::array_tag_t tag    = mem_pkg::array_src
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  mem_pkg::read_rsp_t   read_rsp,
	input  mem_pkg::elem_count_t chunk_offset,
	input  mem_pkg::elem_count_t chunk_count,
	input  logic                 shift,
	output elem_t                elem,
	output logic                 elem_valid,
	output logic                 pending
);
	import mem_pkg::*;

	localparam int elem_bits = elem_bytes * 8;

	line_t       line_q;
	elem_count_t index;
	elem_count_t left;
	logic        capture;

	// only lines for this array
	assign capture = read_rsp.valid && (read_rsp.tag == tag);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending    <= 1'b0;
			index      <= '0;
			left       <= '0;
			elem_valid <= 1'b0;
		end else begin
			elem_valid <= shift && pending;
			if (capture) begin
				pending <= 1'b1;
				index   <= chunk_offset;
				left    <= chunk_count;
			end else if (shift && pending) begin
				index <= index + 1'b1;
				left  <= left - 1'b1;
				// last element of the chunk
				if (left == elem_count_t'(1)) begin
					pending <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			line_q <= read_rsp.data;
		end
		if (shift && pending) begin
			elem <= elem_t'(line_q[index * elem_bits +: elem_bits]);
		end
	end

	line_while_pending: assert property (@(posedge clock) disable iff (!rstn)
		capture |-> !pending);

endmodule

//--- logic/edge_job_control.sv
// edge fetch stage top
module edge_job_control #(
	parameter int fifo_depth  = 16,
	parameter int fifo_margin = 4
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   cfg_write,
	input  mem_pkg::array_tag_t    cfg_tag,
	input  mem_pkg::addr_t         cfg_addr,
	input  graph_pkg::vertex_job_t vertex_job,
	input  mem_pkg::read_rsp_t     read_rsp,
	input  logic                   read_stall,
	input  logic                   edge_pop,
	output mem_pkg::read_cmd_t     read_cmd,
	output graph_pkg::edge_job_t   edge_job,
	output logic                   busy,
	output graph_pkg::edge_idx_t   edges_pushed
);
	import mem_pkg::*;
	import graph_pkg::*;

	addr_t       src_base;
	addr_t       dest_base;
	addr_t       weight_base;
	elem_count_t chunk_offset;
	elem_count_t chunk_count;
	vertex_id_t  src_elem;
	vertex_id_t  dest_elem;
	weight_t     weight_elem;
	logic        src_valid;
	logic        dest_valid;
	logic        weight_valid;
	logic        src_pending;
	logic        dest_pending;
	logic        weight_pending;
	logic        fifo_almost_full;
	logic        shift;
	logic        all_valid;
	logic        streams_idle;
	edge_job_t   edge_q;
	edge_idx_t   edge_id;

	edge_base_regs base_regs_i (
		.clock       (clock),
		.rstn        (rstn),
		.cfg_write   (cfg_write),
		.cfg_tag     (cfg_tag),
		.cfg_addr    (cfg_addr),
		.src_base    (src_base),
		.dest_base   (dest_base),
		.weight_base (weight_base)
	);

	edge_read_sequencer sequencer_i (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_job       (vertex_job),
		.src_base         (src_base),
		.dest_base        (dest_base),
		.weight_base      (weight_base),
		.read_stall       (read_stall),
		.rsp_seen         (read_rsp.valid),
		.streams_idle     (streams_idle),
		.fifo_almost_full (fifo_almost_full),
		.read_cmd         (read_cmd),
		.chunk_offset     (chunk_offset),
		.chunk_count      (chunk_count),
		.busy             (busy)
	);

	////////////////////////////////////////////////////////////
	// array streams
	////////////////////////////////////////////////////////////

	edge_cacheline_stream #(.elem_t(vertex_id_t), .tag(array_src)) src_stream_i (
		.clock        (clock),
		.rstn         (rstn),
		.read_rsp     (read_rsp),
		.chunk_offset (chunk_offset),
		.chunk_count  (chunk_count),
		.shift        (shift),
		.elem         (src_elem),
		.elem_valid   (src_valid),
		.pending      (src_pending)
	);

	edge_cacheline_stream #(.elem_t(vertex_id_t), .tag(array_dest)) dest_stream_i (
		.clock        (clock),
		.rstn         (rstn),
		.read_rsp     (read_rsp),
		.chunk_offset (chunk_offset),
		.chunk_count  (chunk_count),
		.shift        (shift),
		.elem         (dest_elem),
		.elem_valid   (dest_valid),
		.pending      (dest_pending)
	);

	edge_cacheline_stream #(.elem_t(weight_t), .tag(array_weight)) weight_stream_i (
		.clock        (clock),
		.rstn         (rstn),
		.read_rsp     (read_rsp),
		.chunk_offset (chunk_offset),
		.chunk_count  (chunk_count),
		.shift        (shift),
		.elem         (weight_elem),
		.elem_valid   (weight_valid),
		.pending      (weight_pending)
	);

	// shift only once all three lines are in
	assign shift     = src_pending && dest_pending && weight_pending && !fifo_almost_full;
	assign all_valid = src_valid && dest_valid && weight_valid;

	// idle once the last element has left the assembly stage
	assign streams_idle = !(src_pending || dest_pending || weight_pending)
		&& !(src_valid || dest_valid || weight_valid) && !edge_q.valid;

	////////////////////////////////////////////////////////////
	// edge assembly
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_q  <= '0;
			edge_id <= '0;
		end else begin
			edge_q.valid <= all_valid;
			if (all_valid) begin
				edge_q.id     <= edge_id;
				edge_q.src    <= src_elem;
				edge_q.dest   <= dest_elem;
				edge_q.weight <= weight_elem;
				edge_id       <= edge_id + 1'b1;
			end
		end
	end

	// per vertex count, restarted on each accepted job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edges_pushed <= '0;
		end else if (vertex_job.valid && !busy) begin
			edges_pushed <= '0;
		end else if (edge_q.valid) begin
			edges_pushed <= edges_pushed + 1'b1;
		end
	end

	edge_job_fifo #(
		.depth   (fifo_depth),
		.margin  (fifo_margin),
		.entry_t (edge_job_t)
	) edge_fifo_i (
		.clock       (clock),
		.rstn        (rstn),
		.push        (edge_q.valid),
		.entry_in    (edge_q),
		.pop         (edge_pop),
		.head        (edge_job),
		.almost_full (fifo_almost_full)
	);

endmodule

//--- logic/edge_job_fifo.sv
// show-ahead edge job FIFO
module edge_job_fifo #(
	parameter int  depth   = 16,
	parameter int  margin  = 4,
	parameter type entry_t = graph_pkg::edge_job_t
) (
	input  logic   clock,
	input  logic   rstn,
	input  logic   push,
	input  entry_t entry_in,
	input  logic   pop,
	output entry_t head,
	output logic   almost_full
);
	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

	entry_t                     mem [depth];
	logic [ptr_bits-1:0]        wr_ptr;
	logic [ptr_bits-1:0]        rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic                       full;
	logic                       empty;

	assign full        = (count == depth);
	assign empty       = (count == '0);
	assign almost_full = (count >= depth - margin);

	// head shows the oldest entry; valid only with data
	always_comb begin
		head       = mem[rd_ptr];
		head.valid = !empty;
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= entry_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		(push |-> !full) and (pop |-> !empty));

endmodule

//--- logic/edge_read_sequencer.sv
// edge chunk read sequencer
module edge_read_sequencer (
	input  logic                 clock,
	input  logic                 rstn,
	input  graph_pkg::vertex_job_t vertex_job,
	input  mem_pkg::addr_t       src_base,
	input  mem_pkg::addr_t       dest_base,
	input  mem_pkg::addr_t       weight_base,
	input  logic                 read_stall,
	input  logic                 rsp_seen,
	input  logic                 streams_idle,
	input  logic                 fifo_almost_full,
	output mem_pkg::read_cmd_t   read_cmd,
	output mem_pkg::elem_count_t chunk_offset,
	output mem_pkg::elem_count_t chunk_count,
	output logic                 busy
);
	import mem_pkg::*;
	import graph_pkg::*;

	localparam int off_bits   = $clog2(line_bytes);
	localparam int elem_shift = $clog2(elem_bytes);

	typedef enum logic [2:0] {
		st_idle,
		st_gate,
		st_size,
		st_src,
		st_dest,
		st_weight
	} seq_state_t;

	seq_state_t          state;
	addr_t               offset;
	addr_t               aligned;
	req_size_t           req_size;
	edge_idx_t           remaining;
	logic [1:0]          outstanding;
	logic [off_bits-1:0] remainder;
	elem_count_t         lead;
	elem_count_t         avail;
	elem_count_t         count;
	logic                quiet;

	// smallest power of two, at least one element, covering n elements
	function automatic req_size_t cover_size(input elem_count_t n);
		int bytes;
		int size;
		bytes = n * elem_bytes;
		size  = elem_bytes;
		for (int i = 0; i < 8; i++) begin
			if (size < bytes) begin
				size = size * 2;
			end
		end
		return req_size_t'(size);
	endfunction

	////////////////////////////////////////////////////////////
	// chunk sizing
	////////////////////////////////////////////////////////////

	assign remainder = offset[off_bits-1:0];
	assign lead      = elem_count_t'(remainder >> elem_shift);
	assign avail     = elem_count_t'(line_elems) - lead;
	assign count     = (remaining < edge_idx_t'(avail)) ? elem_count_t'(remaining) : avail;

	// nothing in flight anywhere on the read path
	assign quiet = (outstanding == '0) && !read_cmd.valid && streams_idle;

	always_ff @(posedge clock) begin
		if (state == st_idle && vertex_job.valid) begin
			offset <= addr_t'(vertex_job.edges_idx) << elem_shift;
		end else if (state == st_size) begin
			aligned  <= offset & ~addr_t'(line_bytes - 1);
			// misaligned chunks fetch the whole line
			req_size <= (remainder != '0) ? req_size_t'(line_bytes) : cover_size(count);
			offset   <= offset + (addr_t'(count) << elem_shift);
		end
	end

	////////////////////////////////////////////////////////////
	// command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= st_idle;
			busy         <= 1'b0;
			remaining    <= '0;
			read_cmd     <= '0;
			chunk_offset <= '0;
			chunk_count  <= '0;
		end else begin
			read_cmd.valid <= 1'b0;
			case (state)
				st_idle: begin
					if (vertex_job.valid) begin
						busy      <= 1'b1;
						remaining <= vertex_job.out_degree;
						state     <= st_gate;
					end
				end
				st_gate: begin
					if (remaining == '0) begin
						if (quiet) begin
							busy  <= 1'b0;
							state <= st_idle;
						end
					end else if (quiet && !fifo_almost_full) begin
						state <= st_size;
					end
				end
				st_size: begin
					chunk_offset <= lead;
					chunk_count  <= count;
					remaining    <= remaining - edge_idx_t'(count);
					state        <= st_src;
				end
				st_src: begin
					if (!read_stall) begin
						read_cmd <= '{valid: 1'b1, tag: array_src,
							address: src_base + aligned, size: req_size};
						state    <= st_dest;
					end
				end
				st_dest: begin
					if (!read_stall) begin
						read_cmd <= '{valid: 1'b1, tag: array_dest,
							address: dest_base + aligned, size: req_size};
						state    <= st_weight;
					end
				end
				st_weight: begin
					if (!read_stall) begin
						read_cmd <= '{valid: 1'b1, tag: array_weight,
							address: weight_base + aligned, size: req_size};
						state    <= st_gate;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// responses still owed for issued commands
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({read_cmd.valid, rsp_seen})
				2'b10: begin
					outstanding <= outstanding + 1'b1;
				end
				2'b01: begin
					outstanding <= outstanding - 1'b1;
				end
				default: begin
					outstanding <= outstanding;
				end
			endcase
		end
	end

	rsp_without_cmd: assert property (@(posedge clock) disable iff (!rstn)
		rsp_seen |-> outstanding != '0);

endmodule

//--- logic/graph_pkg.sv
// graph payload definitions
package graph_pkg;

	typedef logic [31:0] vertex_id_t;
	typedef logic [31:0] weight_t;
	typedef logic [31:0] edge_idx_t;

	// valid is a one cycle strobe
	typedef struct packed {
		logic       valid;
		vertex_id_t id;
		edge_idx_t  edges_idx;
		edge_idx_t  out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic       valid;
		edge_idx_t  id;
		vertex_id_t src;
		vertex_id_t dest;
		weight_t    weight;
	} edge_job_t;

endpackage

//--- logic/mem_pkg.sv
// memory side definitions
package mem_pkg;

	// cacheline geometry
	localparam int line_bytes = 64;
	localparam int elem_bytes = 4;
	localparam int line_elems = line_bytes / elem_bytes;

	typedef logic [63:0]  addr_t;
	typedef logic [511:0] line_t;
	typedef logic [7:0]   req_size_t;
	typedef logic [4:0]   elem_count_t;

	// which edge array a command or response belongs to
	typedef enum logic [1:0] {
		array_src    = 2'd0,
		array_dest   = 2'd1,
		array_weight = 2'd2
	} array_tag_t;

	typedef struct packed {
		logic       valid;
		array_tag_t tag;
		addr_t      address;
		req_size_t  size;
	} read_cmd_t;

	// one whole line per response, element 0 in the low bits
	typedef struct packed {
		logic       valid;
		array_tag_t tag;
		line_t      data;
	} read_rsp_t;

endpackage

//--- tb/edge_job_cases.txt
# edges_idx out_degree src_bias dest_bias weight_bias commands stall
# one vertex per line, all values decimal
0 16 1000 5000 70000 3 0
16 5 2000 6000 80000 3 0
21 30 3000 7000 90000 9 0
3 1 100 200 300 3 0
100 40 4000 8000 100000 9 1
64 1 0 0 0 3 0
250 20 11 22 33 6 1
32 2 500 600 700 3 0
7 9 9000 9100 9200 3 1

//--- tb/tb_edge_job_control.sv
// edge fetch stage testbench
module tb_edge_job_control;
	timeunit 1ns;
	timeprecision 1ps;

	import mem_pkg::*;
	import graph_pkg::*;

	localparam int period       = 4;
	localparam int drive_delay  = 1;
	localparam int reset_cycles = 4;

	// one vertex case from the data file
	typedef struct packed {
		edge_idx_t   edges_idx;
		edge_idx_t   out_degree;
		logic [31:0] src_bias;
		logic [31:0] dest_bias;
		logic [31:0] weight_bias;
		edge_idx_t   cmds;
		logic        stall;
	} case_t;

	logic        clock;
	logic        rstn;
	logic        cfg_write;
	array_tag_t  cfg_tag;
	addr_t       cfg_addr;
	vertex_job_t vertex_job;
	read_rsp_t   read_rsp;
	logic        read_stall;
	logic        edge_pop;
	read_cmd_t   read_cmd;
	edge_job_t   edge_job;
	logic        busy;
	edge_idx_t   edges_pushed;

	case_t       cases[$];
	read_cmd_t   exp_cmds[$];
	edge_job_t   exp_edges[$];
	read_rsp_t   rsp_q[$];
	int          rsp_due[$];
	addr_t       base[3];
	logic [31:0] bias[3];
	logic [15:0] lfsr;
	edge_idx_t   next_edge_id;
	int          cycle;
	int          cmd_seen;
	int          stall_left;
	int          pop_left;
	logic        cur_stall;
	logic        stall_level;
	logic        hold_pop;
	int          watchdog_cycles;
	int          cmd_errors;
	int          edge_errors;
	int          count_errors;
	int          other_errors;

	edge_job_control dut_i (
		.clock        (clock),
		.rstn         (rstn),
		.cfg_write    (cfg_write),
		.cfg_tag      (cfg_tag),
		.cfg_addr     (cfg_addr),
		.vertex_job   (vertex_job),
		.read_rsp     (read_rsp),
		.read_stall   (read_stall),
		.edge_pop     (edge_pop),
		.read_cmd     (read_cmd),
		.edge_job     (edge_job),
		.busy         (busy),
		.edges_pushed (edges_pushed)
	);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois LFSR, one step per bit taken
	function automatic int draw_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	// smallest power of two from one element up that holds n elements
	function automatic req_size_t covering_size(input int n);
		int size;
		size = elem_bytes;
		while (size < n * elem_bytes) begin
			size = size * 2;
		end
		return req_size_t'(size);
	endfunction

	// memory rule: element i of an array holds i plus the array bias
	function automatic line_t line_for(input array_tag_t tag, input addr_t address);
		line_t       data;
		logic [31:0] first;
		first = 32'((address - base[tag]) / elem_bytes);
		for (int k = 0; k < line_elems; k++) begin
			data[k*32 +: 32] = first + 32'(k) + bias[tag];
		end
		return data;
	endfunction

	task automatic check_cmd(input read_cmd_t got, input read_cmd_t exp);
		if (got !== exp) begin
			cmd_errors++;
			$display("ERR %0t: command tag %0d addr %h size %0d, expected tag %0d addr %h size %0d",
				$time, got.tag, got.address, got.size, exp.tag, exp.address, exp.size);
		end
	endtask

	task automatic check_edge(input edge_job_t got, input edge_job_t exp);
		if (got !== exp) begin
			edge_errors++;
			$display("ERR %0t: edge %0d src %0d dest %0d weight %0d", $time,
				got.id, got.src, got.dest, got.weight);
			$display("ERR %0t: expected edge %0d src %0d dest %0d weight %0d", $time,
				exp.id, exp.src, exp.dest, exp.weight);
		end
	endtask

	task automatic check_count(input edge_idx_t got, input edge_idx_t exp, input string what);
		if (got !== exp) begin
			count_errors++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		int total;
		total = cmd_errors + edge_errors + count_errors + other_errors;
		$display("errors: command %0d edge %0d count %0d other %0d",
			cmd_errors, edge_errors, count_errors, other_errors);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic load_cases();
		int    fd;
		int    r;
		int    a[7];
		string line;
		case_t c;
		fd = $fopen("tb/edge_job_cases.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the case file tb/edge_job_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				r    = $fgets(line, fd);
				if (line.len() > 0 && line[0] != "#") begin
					r = $sscanf(line, "%d %d %d %d %d %d %d",
						a[0], a[1], a[2], a[3], a[4], a[5], a[6]);
					if (r == 7) begin
						c.edges_idx   = edge_idx_t'(a[0]);
						c.out_degree  = edge_idx_t'(a[1]);
						c.src_bias    = 32'(a[2]);
						c.dest_bias   = 32'(a[3]);
						c.weight_bias = 32'(a[4]);
						c.cmds        = edge_idx_t'(a[5]);
						c.stall       = a[6] != 0;
						cases.push_back(c);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// expected commands and edges of one vertex, from the sizing rules
	task automatic plan_case(input case_t c);
		addr_t     offset;
		addr_t     aligned;
		edge_idx_t left;
		int        lead;
		int        cnt;
		req_size_t size;
		read_cmd_t cmd;
		edge_job_t e;
		offset = addr_t'(c.edges_idx) * elem_bytes;
		left   = c.out_degree;
		while (left != 0) begin
			lead    = int'(offset % line_bytes) / elem_bytes;
			cnt     = line_elems - lead;
			aligned = offset - (offset % line_bytes);
			if (left < edge_idx_t'(cnt)) begin
				cnt = int'(left);
			end
			size = (lead != 0) ? req_size_t'(line_bytes) : covering_size(cnt);
			for (int t = 0; t < 3; t++) begin
				cmd.valid   = 1'b1;
				cmd.tag     = array_tag_t'(t);
				cmd.address = base[t] + aligned;
				cmd.size    = size;
				exp_cmds.push_back(cmd);
			end
			offset = offset + addr_t'(cnt * elem_bytes);
			left   = left - edge_idx_t'(cnt);
		end
		for (edge_idx_t i = 0; i < c.out_degree; i++) begin
			e.valid  = 1'b1;
			e.id     = next_edge_id;
			e.src    = c.edges_idx + i + c.src_bias;
			e.dest   = c.edges_idx + i + c.dest_bias;
			e.weight = c.edges_idx + i + c.weight_bias;
			exp_edges.push_back(e);
			next_edge_id++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// per cycle memory responder and edge consumer
	////////////////////////////////////////////////////////////

	task automatic serve_memory();
		read_rsp_t rsp;
		int        delay;
		int        pick;
		if (read_cmd.valid) begin
			cmd_seen++;
			if (exp_cmds.size() == 0) begin
				other_errors++;
				$display("unexpected read command at %0t, none was expected", $time);
			end else begin
				check_cmd(read_cmd, exp_cmds.pop_front());
			end
			rsp.valid = 1'b1;
			rsp.tag   = read_cmd.tag;
			rsp.data  = line_for(read_cmd.tag, read_cmd.address);
			delay     = draw_bits(3);
			rsp_q.push_back(rsp);
			rsp_due.push_back(cycle + delay + 1);
		end
		// oldest due response goes first
		pick = -1;
		for (int i = 0; i < rsp_q.size(); i++) begin
			if (pick < 0 && rsp_due[i] <= cycle) begin
				pick = i;
			end
		end
		if (pick >= 0) begin
			read_rsp = rsp_q[pick];
			rsp_q.delete(pick);
			rsp_due.delete(pick);
		end else begin
			read_rsp = '0;
		end
	endtask

	task automatic consume_edges();
		if (edge_job.valid && !hold_pop) begin
			edge_pop = 1'b1;
			if (exp_edges.size() == 0) begin
				other_errors++;
				$display("unexpected edge %0d at %0t beyond the expected sequence",
					edge_job.id, $time);
			end else begin
				check_edge(edge_job, exp_edges.pop_front());
			end
		end else begin
			edge_pop = 1'b0;
		end
	endtask

	// random stretches of command stall and withheld pops
	task automatic update_stalls();
		if (cur_stall) begin
			if (stall_left == 0) begin
				stall_left  = draw_bits(3) + 1;
				stall_level = !stall_level;
			end
			stall_left--;
			if (pop_left == 0) begin
				pop_left = draw_bits(4) + 1;
				hold_pop = !hold_pop;
			end
			pop_left--;
		end else begin
			stall_level = 1'b0;
			hold_pop    = 1'b0;
			stall_left  = 0;
			pop_left    = 0;
		end
		read_stall = stall_level;
	endtask

	always @(posedge clock) begin
		#(drive_delay);
		if (rstn) begin
			cycle++;
			serve_memory();
			consume_edges();
			update_stalls();
		end
	end

	////////////////////////////////////////////////////////////
	// case runner
	////////////////////////////////////////////////////////////

	task automatic write_base(input array_tag_t tag, input addr_t address);
		@(posedge clock);
		#(drive_delay);
		cfg_write = 1'b1;
		cfg_tag   = tag;
		cfg_addr  = address;
		@(posedge clock);
		#(drive_delay);
		cfg_write = 1'b0;
	endtask

	task automatic run_case(input int n, input case_t c);
		@(negedge clock);
		cur_stall = c.stall;
		bias[0]   = c.src_bias;
		bias[1]   = c.dest_bias;
		bias[2]   = c.weight_bias;
		cmd_seen  = 0;
		plan_case(c);
		@(posedge clock);
		#(drive_delay);
		vertex_job.valid      = 1'b1;
		vertex_job.id         = vertex_id_t'(32'h100 + n);
		vertex_job.edges_idx  = c.edges_idx;
		vertex_job.out_degree = c.out_degree;
		@(posedge clock);
		#(drive_delay);
		vertex_job = '0;
		@(negedge clock);
		if (!busy) begin
			other_errors++;
			$display("busy did not rise after the vertex job of case %0d", n);
		end
		while (busy) begin
			@(negedge clock);
		end
		check_count(edges_pushed, c.out_degree, "edges pushed");
		check_count(edge_idx_t'(cmd_seen), c.cmds, "read commands");
		repeat (3) @(negedge clock);
		// nothing more may land for a finished vertex
		check_count(edges_pushed, c.out_degree, "edges pushed after busy fell");
	endtask

	initial begin
		int limit;
		rstn            = 1'b0;
		cfg_write       = 1'b0;
		cfg_tag         = array_src;
		cfg_addr        = '0;
		vertex_job      = '0;
		read_rsp        = '0;
		read_stall      = 1'b0;
		edge_pop        = 1'b0;
		lfsr            = 16'd87;
		next_edge_id    = '0;
		cycle           = 0;
		cmd_seen        = 0;
		stall_left      = 0;
		pop_left        = 0;
		cur_stall       = 1'b0;
		stall_level     = 1'b0;
		hold_pop        = 1'b0;
		watchdog_cycles = 0;
		cmd_errors      = 0;
		edge_errors     = 0;
		count_errors    = 0;
		other_errors    = 0;
		base[0]         = 64'h0000_0001_0000_0000;
		base[1]         = 64'h0000_0002_0000_1000;
		base[2]         = 64'h0000_0003_0040_0000;
		bias            = '{default: '0};
		load_cases();
		if (cases.size() == 0) begin
			other_errors++;
			$display("the case file holds no usable case");
		end
		limit = 0;
		foreach (cases[i]) begin
			limit += (int'(cases[i].out_degree) + 40) * 4;
		end
		watchdog_cycles = limit;
		repeat (reset_cycles) @(posedge clock);
		#(drive_delay);
		rstn = 1'b1;
		@(negedge clock);
		// outputs idle straight after reset
		if (busy || edge_job.valid || read_cmd.valid) begin
			other_errors++;
			$display("busy, edge valid or command valid is not low after reset");
		end
		check_count(edges_pushed, '0, "edges pushed after reset");
		write_base(array_src, base[0]);
		write_base(array_dest, base[1]);
		write_base(array_weight, base[2]);
		foreach (cases[i]) begin
			run_case(i, cases[i]);
		end
		cur_stall = 1'b0;
		while (exp_edges.size() != 0) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
		if (edge_job.valid) begin
			other_errors++;
			$display("an edge job is still queued after the last expected edge");
		end
		finish_run();
	end

	// hard limit on the whole run
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		other_errors++;
		$display("timeout after %0d cycles, busy is %0b and %0d edges never arrived",
			watchdog_cycles, busy, exp_edges.size());
		finish_run();
	end

endmodule
